/* rtl/muldiv_pkg.sv */
/*
 * Multiply/divide unit shared definitions
 * Word types, operation and state encodings, bus structs, register map
 */

`default_nettype none

package muldiv_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Operand width, everything else follows from it
  localparam int unsigned word_bits = 32;

  typedef logic [word_bits-1:0]   word_t;
  // Product, or remainder:quotient pair while dividing
  typedef logic [2*word_bits-1:0] dword_t;
  typedef logic [7:0]             apb_addr_t;
  // Holds 0 to 32
  typedef logic [5:0]             step_count_t;

  // One iteration per operand bit
  localparam step_count_t num_steps = step_count_t'(word_bits);

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------

  // Matches bit 0 of the CTRL register
  typedef enum logic {
    op_mul = 1'b0,
    op_div = 1'b1
  } op_e;

  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_calc   = 2'd1,
    st_finish = 2'd2
  } ctrl_state_e;

  // ----------------------------------------------------------------------
  // Front to controller, controller to capture
  // ----------------------------------------------------------------------

  typedef struct packed {
    op_e   op;
    word_t a;
    word_t b;
  } muldiv_req_t;

  // lo is product low or quotient, hi is product high or remainder
  typedef struct packed {
    word_t lo;
    word_t hi;
    logic  div_by_zero;
  } muldiv_rsp_t;

  // ----------------------------------------------------------------------
  // Register map, byte offsets
  // ----------------------------------------------------------------------

  localparam apb_addr_t addr_opa    = 8'h00;
  localparam apb_addr_t addr_opb    = 8'h04;
  localparam apb_addr_t addr_ctrl   = 8'h08;
  localparam apb_addr_t addr_status = 8'h0C;
  localparam apb_addr_t addr_res_lo = 8'h10;
  localparam apb_addr_t addr_res_hi = 8'h14;

endpackage

`default_nettype wire

/* rtl/muldiv_step.sv */
/*
 * One iteration of shift-add multiply or restoring divide
 */

`timescale 1ns/100ps
`default_nettype none

module muldiv_step (
  input  wire muldiv_pkg::op_e     op,
  input  wire muldiv_pkg::dword_t  acc,
  input  wire muldiv_pkg::word_t   operand,
  // Multiply: current multiplier bit. Divide: previous quotient bit
  input  wire                      lsb_bit,
  output muldiv_pkg::dword_t       next_acc,
  // Multiply: next multiplier bit. Divide: new quotient bit
  output logic                     next_bit
);

  localparam int unsigned w = muldiv_pkg::word_bits;

  // Multiply side
  muldiv_pkg::word_t  addend;
  logic [w:0]         mul_sum;
  muldiv_pkg::dword_t mul_next;

  // Divide side
  logic [w:0]         div_part;
  logic [w:0]         div_diff;
  logic               div_fits;
  muldiv_pkg::word_t  div_rem;
  muldiv_pkg::dword_t div_next;

  // ----------------------------------------------------------------------
  // Multiply, acc is {partial product, remaining multiplier}
  // ----------------------------------------------------------------------

  // Add multiplicand only when the multiplier bit is set
  assign addend   = lsb_bit ? operand : '0;
  assign mul_sum  = {1'b0, acc[2*w-1:w]} + {1'b0, addend};
  // Carry drops into the top, multiplier shifts out the bottom
  assign mul_next = {mul_sum, acc[w-1:1]};

  // ----------------------------------------------------------------------
  // Divide, acc is {partial remainder, remaining dividend}
  // ----------------------------------------------------------------------

  // Remainder after the left shift, one extra bit for overflow
  assign div_part = acc[2*w-1:w-1];
  // No borrow when the divisor fits
  assign div_fits = div_part >= {1'b0, operand};
  assign div_diff = div_part - {1'b0, operand};
  // Restore on borrow
  assign div_rem  = div_fits ? div_diff[w-1:0] : div_part[w-1:0];
  // Previous quotient bit enters at the bottom
  assign div_next = {div_rem, acc[w-2:0], lsb_bit};

  // ----------------------------------------------------------------------
  // Select by operation
  // ----------------------------------------------------------------------

  assign next_acc = (op == muldiv_pkg::op_mul) ? mul_next : div_next;
  assign next_bit = (op == muldiv_pkg::op_mul) ? acc[1] : div_fits;

endmodule

`default_nettype wire

/* rtl/muldiv_ctrl.sv */
/*
 * Iteration controller for multiply/divide
 * Loads a request, runs one step per clock for 32 clocks, hands the result off
 */

`timescale 1ns/100ps
`default_nettype none

module muldiv_ctrl (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           start,
  input  wire muldiv_pkg::muldiv_req_t  req,
  output logic                          busy,
  output logic                          finish,
  output muldiv_pkg::muldiv_rsp_t       rsp
);

  localparam int unsigned w = muldiv_pkg::word_bits;

  muldiv_pkg::ctrl_state_e state_q;
  muldiv_pkg::step_count_t count_q;
  logic                    load;
  logic                    last_step;

  // Working registers
  muldiv_pkg::dword_t      acc_q;
  muldiv_pkg::word_t       operand_q;
  muldiv_pkg::op_e         op_q;
  // Decision bit carried between steps
  logic                    bit_q;
  logic                    b_zero_q;

  muldiv_pkg::dword_t      next_acc;
  logic                    next_bit;

  assign load      = start & (state_q == muldiv_pkg::st_idle);
  assign last_step = count_q == muldiv_pkg::step_count_t'(muldiv_pkg::num_steps - 1'b1);

  // Covers the start cycle before the FSM leaves idle
  assign busy   = start | (state_q != muldiv_pkg::st_idle);
  assign finish = state_q == muldiv_pkg::st_finish;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= muldiv_pkg::st_idle;
      count_q <= '0;
    end else begin
      case (state_q)
        muldiv_pkg::st_idle: begin
          if (start) begin
            state_q <= muldiv_pkg::st_calc;
            count_q <= '0;
          end
        end
        muldiv_pkg::st_calc: begin
          count_q <= count_q + 1'b1;
          if (last_step) begin
            state_q <= muldiv_pkg::st_finish;
          end
        end
        // Single result cycle
        muldiv_pkg::st_finish: state_q <= muldiv_pkg::st_idle;
        default:               state_q <= muldiv_pkg::st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      // Operand a starts in the low half for both operations
      acc_q     <= {{w{1'b0}}, req.a};
      operand_q <= req.b;
      op_q      <= req.op;
      b_zero_q  <= req.b == '0;
      // First multiplier bit, or an empty quotient slot
      bit_q     <= (req.op == muldiv_pkg::op_mul) ? req.a[0] : 1'b0;
    end else if (state_q == muldiv_pkg::st_calc) begin
      acc_q <= next_acc;
      bit_q <= next_bit;
    end
  end

  muldiv_step muldiv_step_inst (
    .op       (op_q),
    .acc      (acc_q),
    .operand  (operand_q),
    .lsb_bit  (bit_q),
    .next_acc (next_acc),
    .next_bit (next_bit)
  );

  // Result split, valid in st_finish
  always_comb begin
    rsp.hi = acc_q[2*w-1:w];
    if (op_q == muldiv_pkg::op_mul) begin
      rsp.lo = acc_q[w-1:0];
    end else begin
      // Last quotient bit is still in bit_q
      rsp.lo = {acc_q[w-2:0], bit_q};
    end
    rsp.div_by_zero = (op_q == muldiv_pkg::op_div) & b_zero_q;
  end

endmodule

`default_nettype wire

/* rtl/apb_reg_front.sv */
/*
 * APB register front of the multiply/divide unit
 * Holds operands, launches operations, serves status and result reads
 */

`timescale 1ns/100ps
`default_nettype none

module apb_reg_front (
  input  wire                          clk,
  input  wire                          rst_n,
  // APB slave side
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire muldiv_pkg::apb_addr_t   paddr,
  input  wire muldiv_pkg::word_t       pwdata,
  output muldiv_pkg::word_t            prdata,
  output logic                         pready,
  output logic                         pslverr,
  // Status and results coming back
  input  wire                          busy,
  input  wire                          done,
  input  wire                          div_by_zero,
  input  wire muldiv_pkg::word_t       res_lo,
  input  wire muldiv_pkg::word_t       res_hi,
  // Launch towards the controller
  output logic                         start,
  output muldiv_pkg::muldiv_req_t      req
);

  // Access phase of a transfer
  logic              access;
  logic              addr_hit;
  // OPA, OPB or CTRL, the registers locked while busy
  logic              locked_addr;
  logic              reject;
  logic              wr_ok;
  muldiv_pkg::word_t opa_q;
  muldiv_pkg::word_t opb_q;

  // ----------------------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------------------

  // No wait states
  assign pready = 1'b1;
  assign access = psel & penable;

  assign locked_addr = (paddr == muldiv_pkg::addr_opa) ||
                       (paddr == muldiv_pkg::addr_opb) ||
                       (paddr == muldiv_pkg::addr_ctrl);

  // Writes into an operation in flight bounce
  assign reject  = pwrite & busy & locked_addr;
  assign pslverr = access & (~addr_hit | reject);
  // Status and result writes land here too, and are simply dropped
  assign wr_ok   = access & pwrite & addr_hit & ~reject;

  // Address hit check and read mux in one place
  always_comb begin
    addr_hit = 1'b1;
    prdata   = '0;
    case (paddr)
      muldiv_pkg::addr_opa:    prdata = opa_q;
      muldiv_pkg::addr_opb:    prdata = opb_q;
      // CTRL reads back as zero
      muldiv_pkg::addr_ctrl:   prdata = '0;
      muldiv_pkg::addr_status: prdata[2:0] = {div_by_zero, done, busy};
      muldiv_pkg::addr_res_lo: prdata = res_lo;
      muldiv_pkg::addr_res_hi: prdata = res_hi;
      default:                 addr_hit = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Operand registers and start pulse
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opa_q <= '0;
      opb_q <= '0;
      start <= 1'b0;
    end else begin
      // Pulse lasts one cycle
      start <= 1'b0;
      if (wr_ok && paddr == muldiv_pkg::addr_opa) begin
        opa_q <= pwdata;
      end
      if (wr_ok && paddr == muldiv_pkg::addr_opb) begin
        opb_q <= pwdata;
      end
      if (wr_ok && paddr == muldiv_pkg::addr_ctrl) begin
        start <= 1'b1;
      end
    end
  end

  // Request snapshot taken with the CTRL write
  always_ff @(posedge clk) begin
    if (wr_ok && paddr == muldiv_pkg::addr_ctrl) begin
      req.op <= muldiv_pkg::op_e'(pwdata[0]);
      req.a  <= opa_q;
      req.b  <= opb_q;
    end
  end

endmodule

`default_nettype wire

/* rtl/result_capture.sv */
/*
 * Result capture, holds the last result and the sticky status bits
 */

`timescale 1ns/100ps
`default_nettype none

module result_capture (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           start,
  input  wire                           finish,
  input  wire muldiv_pkg::muldiv_rsp_t  rsp,
  output logic                          done,
  output logic                          div_by_zero,
  output muldiv_pkg::word_t             res_lo,
  output muldiv_pkg::word_t             res_hi
);

  // Status bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done        <= 1'b0;
      div_by_zero <= 1'b0;
    end else if (start) begin
      // New operation clears the flags
      done        <= 1'b0;
      div_by_zero <= 1'b0;
    end else if (finish) begin
      done        <= 1'b1;
      div_by_zero <= rsp.div_by_zero;
    end
  end

  // Result words, kept until the next finish
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_lo <= '0;
      res_hi <= '0;
    end else if (finish) begin
      res_lo <= rsp.lo;
      res_hi <= rsp.hi;
    end
  end

endmodule

`default_nettype wire

/* rtl/muldiv_top.sv */
/*
 * APB multiply/divide unit, top level
 */

`timescale 1ns/100ps
`default_nettype none

module muldiv_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  wire muldiv_pkg::apb_addr_t  paddr,
  input  wire muldiv_pkg::word_t      pwdata,
  output muldiv_pkg::word_t           prdata,
  output logic                        pready,
  output logic                        pslverr
);

  // Front to controller
  logic                    start;
  muldiv_pkg::muldiv_req_t req;
  logic                    busy;

  // Controller to capture
  logic                    finish;
  muldiv_pkg::muldiv_rsp_t rsp;

  // Capture back to front
  logic                    done;
  logic                    div_by_zero;
  muldiv_pkg::word_t       res_lo;
  muldiv_pkg::word_t       res_hi;

  apb_reg_front apb_reg_front_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .busy        (busy),
    .done        (done),
    .div_by_zero (div_by_zero),
    .res_lo      (res_lo),
    .res_hi      (res_hi),
    .start       (start),
    .req         (req)
  );

  muldiv_ctrl muldiv_ctrl_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .finish (finish),
    .rsp    (rsp)
  );

  result_capture result_capture_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .finish      (finish),
    .rsp         (rsp),
    .done        (done),
    .div_by_zero (div_by_zero),
    .res_lo      (res_lo),
    .res_hi      (res_hi)
  );

endmodule

`default_nettype wire

/* test/muldiv_tb.sv */
/*
 * Testbench for the APB multiply/divide unit
 * Replays vectors from the test data file, checks results, status and bus errors
 */

`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;

  localparam int clk_period  = 100;
  localparam int max_vectors = 64;
  // Status reads before giving up on done
  localparam int poll_limit  = 100;

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  muldiv_pkg::apb_addr_t paddr;
  muldiv_pkg::word_t     pwdata;
  muldiv_pkg::word_t     prdata;
  logic                  pready;
  logic                  pslverr;

  // Vectors as read from the data file
  muldiv_pkg::word_t vec_op [max_vectors];
  muldiv_pkg::word_t vec_a  [max_vectors];
  muldiv_pkg::word_t vec_b  [max_vectors];
  muldiv_pkg::word_t vec_lo [max_vectors];
  muldiv_pkg::word_t vec_hi [max_vectors];
  int num_vectors = 0;

  // Run bookkeeping
  int cycles      = 0;
  int max_cycles  = 200;
  int tests       = 0;
  int checks      = 0;
  int errors      = 0;
  int test_errors = 0;

  muldiv_top muldiv_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Watchdog with its limit set once the vectors are known
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("cycle limit of %0d reached before the tests completed", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // APB transfers of one setup, one access and one idle cycle
  // ----------------------------------------------------------------------

  task automatic apb_access(input logic wr, input muldiv_pkg::apb_addr_t addr,
                            input muldiv_pkg::word_t wdata,
                            output muldiv_pkg::word_t rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Middle of the access phase
    #(clk_period / 4);
    rdata = prdata;
    err   = pslverr;
    // No wait states on this bus
    check_value("pready", 32'd1, {31'd0, pready});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input muldiv_pkg::apb_addr_t addr, input muldiv_pkg::word_t data,
                           output logic err);
    muldiv_pkg::word_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input muldiv_pkg::apb_addr_t addr, output muldiv_pkg::word_t data,
                          output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // ----------------------------------------------------------------------
  // Checking and reporting
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input muldiv_pkg::word_t expected,
                             input muldiv_pkg::word_t actual);
    checks++;
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s expected %h actual %h", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, test_errors);
    end
    test_errors = 0;
  endtask

  // Reads STATUS until done and leaves the last value in status
  task automatic wait_done(output muldiv_pkg::word_t status);
    logic err;
    int   polls;
    polls  = 0;
    status = '0;
    while (status[1] == 1'b0 && polls < poll_limit) begin
      apb_read(muldiv_pkg::addr_status, status, err);
      polls++;
    end
    if (status[1] == 1'b0) begin
      $display("timeout at time %0t: done not set after %0d status reads", $time, polls);
      errors++;
      test_errors++;
    end
  endtask

  // Operands then CTRL with no write rejected
  task automatic start_op(input muldiv_pkg::word_t op, input muldiv_pkg::word_t a,
                          input muldiv_pkg::word_t b);
    logic err;
    apb_write(muldiv_pkg::addr_opa, a, err);
    check_value("pslverr", 32'd0, {31'd0, err});
    apb_write(muldiv_pkg::addr_opb, b, err);
    check_value("pslverr", 32'd0, {31'd0, err});
    apb_write(muldiv_pkg::addr_ctrl, op, err);
    check_value("pslverr", 32'd0, {31'd0, err});
  endtask

  task automatic check_results(input muldiv_pkg::word_t lo, input muldiv_pkg::word_t hi);
    muldiv_pkg::word_t data;
    logic              err;
    apb_read(muldiv_pkg::addr_res_lo, data, err);
    check_value("res_lo", lo, data);
    apb_read(muldiv_pkg::addr_res_hi, data, err);
    check_value("res_hi", hi, data);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic load_vectors(output bit ok);
    int                fd;
    int                fields;
    string             line;
    muldiv_pkg::word_t op;
    muldiv_pkg::word_t a;
    muldiv_pkg::word_t b;
    muldiv_pkg::word_t lo;
    muldiv_pkg::word_t hi;
    ok = 1'b0;
    fd = $fopen("test/muldiv_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file test/muldiv_testdata.txt");
    end else begin
      while (!$feof(fd) && num_vectors < max_vectors) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          // Comment and blank lines do not scan as five fields
          fields = $sscanf(line, "%h %h %h %h %h", op, a, b, lo, hi);
          if (fields == 5) begin
            vec_op[num_vectors] = op;
            vec_a[num_vectors]  = a;
            vec_b[num_vectors]  = b;
            vec_lo[num_vectors] = lo;
            vec_hi[num_vectors] = hi;
            num_vectors++;
          end
        end
      end
      $fclose(fd);
      ok = num_vectors > 0;
      if (!ok) begin
        $display("the test data file holds no vectors");
      end
    end
  endtask

  task automatic check_reset_values();
    muldiv_pkg::word_t data;
    logic              err;
    apb_read(muldiv_pkg::addr_status, data, err);
    check_value("status", 32'd0, data);
    check_results(32'd0, 32'd0);
    report_test("reset values");
  endtask

  task automatic run_vector(input int idx);
    muldiv_pkg::word_t status;
    logic              dbz;
    // Divide by zero shows in status bit 2 next to done
    dbz = vec_op[idx][0] && (vec_b[idx] == '0);
    start_op(vec_op[idx], vec_a[idx], vec_b[idx]);
    wait_done(status);
    check_value("status", {29'd0, dbz, 2'b10}, status);
    check_results(vec_lo[idx], vec_hi[idx]);
    report_test($sformatf("%s %h %h", vec_op[idx][0] ? "div" : "mul", vec_a[idx], vec_b[idx]));
  endtask

  task automatic check_dbz_clear();
    muldiv_pkg::word_t status;
    logic              err;
    start_op({31'd0, muldiv_pkg::op_div}, 32'h0BADF00D, 32'd0);
    wait_done(status);
    check_value("status", 32'h6, status);
    check_results(32'hFFFFFFFF, 32'h0BADF00D);
    // New start clears done and the flag and raises busy
    apb_write(muldiv_pkg::addr_ctrl, {31'd0, muldiv_pkg::op_mul}, err);
    apb_read(muldiv_pkg::addr_status, status, err);
    check_value("status", 32'h1, status);
    wait_done(status);
    check_value("status", 32'h2, status);
    check_results(32'd0, 32'd0);
    report_test("divide by zero flag cleared");
  endtask

  task automatic check_busy_write();
    muldiv_pkg::word_t a;
    muldiv_pkg::word_t b;
    muldiv_pkg::word_t data;
    logic [63:0]       product;
    logic              err;
    a       = 32'h89ABCDEF;
    b       = 32'h00000010;
    product = {32'd0, a} * {32'd0, b};
    start_op({31'd0, muldiv_pkg::op_mul}, a, b);
    // Lands while the operation runs
    apb_write(muldiv_pkg::addr_opa, 32'h00000001, err);
    check_value("pslverr", 32'd1, {31'd0, err});
    wait_done(data);
    check_results(product[31:0], product[63:32]);
    apb_read(muldiv_pkg::addr_opa, data, err);
    check_value("opa", a, data);
    report_test("write while busy");
  endtask

  task automatic check_protocol();
    muldiv_pkg::word_t data;
    logic              err;
    apb_read(8'h18, data, err);
    check_value("pslverr", 32'd1, {31'd0, err});
    apb_write(8'hFC, 32'h12345678, err);
    check_value("pslverr", 32'd1, {31'd0, err});
    // Operand readback
    apb_write(muldiv_pkg::addr_opa, 32'hA5A55A5A, err);
    apb_write(muldiv_pkg::addr_opb, 32'h0F0F1234, err);
    apb_read(muldiv_pkg::addr_opa, data, err);
    check_value("opa", 32'hA5A55A5A, data);
    check_value("pslverr", 32'd0, {31'd0, err});
    apb_read(muldiv_pkg::addr_opb, data, err);
    check_value("opb", 32'h0F0F1234, data);
    report_test("unmapped access and readback");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    bit ok;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    load_vectors(ok);
    if (ok) begin
      max_cycles = num_vectors * 60 + 200;
    end else begin
      errors++;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (ok) begin
      check_reset_values();
      for (int i = 0; i < num_vectors; i++) begin
        run_vector(i);
      end
      check_dbz_clear();
      check_busy_write();
      check_protocol();
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/muldiv_testdata.txt */
# op (0 mul, 1 div), operand a, operand b, expected lo, expected hi; all hex
# mul gives product low and high, div gives quotient and remainder
0 00000000 12345678 00000000 00000000
0 00000001 DEADBEEF DEADBEEF 00000000
0 FFFFFFFF FFFFFFFF 00000001 FFFFFFFE
0 00010000 00010000 00000000 00000001
0 0000FFFF 0000FFFF FFFE0001 00000000
0 80000000 00000003 80000000 00000001
0 00012345 00010000 23450000 00000001
0 FFFFFFFF 00000002 FFFFFFFE 00000001
0 12345678 00000100 34567800 00000012
0 10000001 10000001 20000001 01000000
1 00000064 00000007 0000000E 00000002
1 00000005 00000009 00000000 00000005
1 DEADBEEF 00000001 DEADBEEF 00000000
1 FFFFFFFF 00000010 0FFFFFFF 0000000F
1 FFFFFFFF FFFFFFFF 00000001 00000000
1 80000000 00000003 2AAAAAAA 00000002
1 12345678 00010000 00001234 00005678
1 00000000 00000005 00000000 00000000
1 12345678 00000000 FFFFFFFF 12345678
1 00000000 00000000 FFFFFFFF 00000000

/* sources.f */
rtl/muldiv_pkg.sv
rtl/muldiv_step.sv
rtl/muldiv_ctrl.sv
rtl/apb_reg_front.sv
rtl/result_capture.sv
rtl/muldiv_top.sv
test/muldiv_tb.sv

/* Makefile */
# Verilator flow for the APB multiply/divide unit

VERILATOR := verilator
FLAGS     := --timing --timescale 1ns/100ps
TOP       := muldiv_tb
RTL_TOP   := muldiv_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
